//--- ddr3_config.svh
`ifndef DDR3_CONFIG_SVH
`define DDR3_CONFIG_SVH

// ****************************************
// memory application port geometry
// ****************************************

// data bits carried by one burst
`define DDR3_DATA_W 128

// byte-free address seen by the memory core
`define DDR3_APP_ADDR_W 27

// index of a 128-bit burst, before scaling to app address units
`define DDR3_BURST_ADDR_W 23

// ****************************************
// sequencing constants
// ****************************************

// width of the read burst count
`define DDR3_BURST_CNT_W 24

// eight 16-bit beats per burst
`define DDR3_ADDR_STEP 8

// flops on the acq_enabled level
`define DDR3_SYNC_STAGES 2

`endif

//--- ddr3_pkg.sv
`default_nettype none

`include "ddr3_config.svh"

package ddr3_pkg;

    // ****************************************
    // application command codes
    // ****************************************

    // encoding as decoded by the memory core
    // other codes unused by this front end
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    // ****************************************
    // command bundle
    // ****************************************

    // one command, requester to arbiter and arbiter to memory
    // code in the upper bits, address below
    typedef struct packed {
        app_cmd_e                    cmd;
        logic [`DDR3_APP_ADDR_W-1:0] addr;
    } app_cmd_t;

    // ****************************************
    // read FIFO entry
    // ****************************************

    // one returned burst plus the end-of-run marker
    // last sits in bit 0
    typedef struct packed {
        logic [`DDR3_DATA_W-1:0] data;
        logic                    last;
    } rd_beat_t;

endpackage

`default_nettype wire

//--- ddr3_wr_control.sv
`default_nettype none

`include "ddr3_config.svh"

module ddr3_wr_control (
    input  wire logic                    ddr3_domain_clk,
    input  wire logic                    rst_n,
    // sample FIFO
    input  wire logic                    ddr3_wr_fifo_empty,
    input  wire logic [`DDR3_DATA_W-1:0] ddr3_wr_fifo_dat,
    output logic                         ddr3_wr_fifo_rd_en,
    // command request toward the arbiter
    output logic                         wr_req,
    output ddr3_pkg::app_cmd_t           wr_cmd,
    input  wire logic                    wr_grant,
    // write data channel
    output logic [`DDR3_DATA_W-1:0]      app_wdf_data,
    output logic                         app_wdf_wren,
    output logic                         app_wdf_end,
    input  wire logic                    app_wdf_rdy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_POP,
        ST_CAPTURE,
        ST_ISSUE
    } wr_state_e;

    wr_state_e                   state;
    logic                        cmd_done;
    logic                        data_done;
    logic                        cmd_fin;
    logic                        data_fin;
    logic [`DDR3_APP_ADDR_W-1:0] wr_addr;
    logic [`DDR3_DATA_W-1:0]     data_q;

    // request and data strobe only while a word is in flight
    assign wr_req       = (state == ST_ISSUE) && !cmd_done;
    assign app_wdf_wren = (state == ST_ISSUE) && !data_done;
    // single-beat bursts, end with every write
    assign app_wdf_end  = app_wdf_wren;
    assign app_wdf_data = data_q;
    assign wr_cmd       = '{cmd: ddr3_pkg::APP_CMD_WRITE, addr: wr_addr};

    // completion seen now or earlier
    assign cmd_fin  = cmd_done || wr_grant;
    assign data_fin = data_done || (app_wdf_wren && app_wdf_rdy);

    // ****************************************
    // word sequencer
    // ****************************************
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= ST_IDLE;
            ddr3_wr_fifo_rd_en <= 1'b0;
            cmd_done           <= 1'b0;
            data_done          <= 1'b0;
            wr_addr            <= '0;
        end else begin
            // rd_en is a one-cycle pulse
            ddr3_wr_fifo_rd_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!ddr3_wr_fifo_empty) begin
                        ddr3_wr_fifo_rd_en <= 1'b1;
                        state              <= ST_POP;
                    end
                end
                // fifo updates its output on this edge
                ST_POP: state <= ST_CAPTURE;
                ST_CAPTURE: state <= ST_ISSUE;
                ST_ISSUE: begin
                    if (cmd_fin && data_fin) begin
                        // both halves accepted, next burst address
                        cmd_done  <= 1'b0;
                        data_done <= 1'b0;
                        wr_addr   <= wr_addr + `DDR3_APP_ADDR_W'(`DDR3_ADDR_STEP);
                        state     <= ST_IDLE;
                    end else begin
                        cmd_done  <= cmd_fin;
                        data_done <= data_fin;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // holding register for the popped word
    always_ff @(posedge ddr3_domain_clk) begin
        if (state == ST_CAPTURE) begin
            data_q <= ddr3_wr_fifo_dat;
        end
    end

    // emptiness was sampled a cycle before the pulse
    a_no_pop_when_empty: assert property (
        @(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_wr_fifo_rd_en |-> !ddr3_wr_fifo_empty
    );

endmodule

`default_nettype wire

//--- ddr3_cmd_arbiter.sv
`default_nettype none

`include "ddr3_config.svh"

module ddr3_cmd_arbiter (
    input  wire logic               ddr3_domain_clk,
    input  wire logic               rst_n,
    // acquisition mode as an asynchronous level
    input  wire logic               acq_enabled,
    // write requester
    input  wire logic               wr_req,
    input  wire ddr3_pkg::app_cmd_t wr_cmd,
    output logic                    wr_grant,
    // read requester
    input  wire logic               rd_req,
    input  wire ddr3_pkg::app_cmd_t rd_cmd,
    output logic                    rd_grant,
    // application command port
    output ddr3_pkg::app_cmd_t      app_cmd,
    output logic                    app_en,
    input  wire logic               app_rdy
);

    logic [`DDR3_SYNC_STAGES-1:0] acq_sync;
    logic                         acq_wr_sel;
    logic                         slot_free;
    logic                         take_cmd;

    // ****************************************
    // acq_enabled synchronizer
    // ****************************************

    // shift chain with the oldest sample at the top
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            acq_sync <= '0;
        end else begin
            acq_sync <= {acq_sync[`DDR3_SYNC_STAGES-2:0], acq_enabled};
        end
    end

    // writes own the port during acquisition and reads own it otherwise
    assign acq_wr_sel = acq_sync[`DDR3_SYNC_STAGES-1];

    // ****************************************
    // request selection
    // ****************************************

    // slot can load when empty or leaving this cycle
    assign slot_free = !app_en || app_rdy;

    // only the mode-selected side can ever win
    assign wr_grant = slot_free && acq_wr_sel && wr_req;
    assign rd_grant = slot_free && !acq_wr_sel && rd_req;
    assign take_cmd = wr_grant || rd_grant;

    // ****************************************
    // one-deep command slot
    // ****************************************

    // valid flag holds under back-pressure
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            app_en <= 1'b0;
        end else if (slot_free) begin
            app_en <= take_cmd;
        end
    end

    // command contents load only on a grant
    always_ff @(posedge ddr3_domain_clk) begin
        if (wr_grant) begin
            app_cmd <= wr_cmd;
        end else if (rd_grant) begin
            app_cmd <= rd_cmd;
        end
    end

    // memory sees a steady command until it takes it
    a_cmd_hold: assert property (
        @(posedge ddr3_domain_clk) disable iff (!rst_n)
        (app_en && !app_rdy) |=> (app_en && $stable(app_cmd))
    );

    // write requester keeps its command steady until granted
    a_wr_req_hold: assert property (
        @(posedge ddr3_domain_clk) disable iff (!rst_n)
        (wr_req && !wr_grant) |=> (wr_req && $stable(wr_cmd))
    );

endmodule

`default_nettype wire

//--- ddr3_rd_control.sv
`default_nettype none

`include "ddr3_config.svh"

module ddr3_rd_control (
    input  wire logic                         ddr3_domain_clk,
    input  wire logic                         rst_n,
    // run setup from the readout logic
    input  wire logic [`DDR3_BURST_ADDR_W-1:0] ddr3_rd_start_addr,
    input  wire logic [`DDR3_BURST_CNT_W-1:0]  ddr3_rd_burst_cnt,
    input  wire logic                         enable_reading,
    output logic                              reading_done,
    // command request toward the arbiter
    output logic                              rd_req,
    output ddr3_pkg::app_cmd_t                rd_cmd,
    input  wire logic                         rd_grant,
    // returned data from memory
    input  wire logic [`DDR3_DATA_W-1:0]      app_rd_data,
    input  wire logic                         app_rd_data_valid,
    // read FIFO
    output logic                              ddr3_rd_fifo_wr_en,
    output ddr3_pkg::rd_beat_t                ddr3_rd_fifo_beat,
    input  wire logic                         ddr3_rd_fifo_almost_full
);

    logic [`DDR3_APP_ADDR_W-1:0]  rd_addr;
    logic [`DDR3_BURST_CNT_W-1:0] req_left;
    logic [`DDR3_BURST_CNT_W-1:0] burst_total;
    logic [`DDR3_BURST_CNT_W-1:0] beat_cnt;
    logic [`DDR3_BURST_CNT_W-1:0] beat_next;
    logic                         last_hit;

    // ****************************************
    // request side
    // ****************************************

    // stop asking while the FIFO is near full
    assign rd_req = (req_left != '0) && !ddr3_rd_fifo_almost_full;
    assign rd_cmd = '{cmd: ddr3_pkg::APP_CMD_READ, addr: rd_addr};

    // address generator and remaining-burst counter
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr  <= '0;
            req_left <= '0;
        end else if (enable_reading) begin
            // burst index scaled to app address units
            rd_addr  <= `DDR3_APP_ADDR_W'(ddr3_rd_start_addr)
                        * `DDR3_APP_ADDR_W'(`DDR3_ADDR_STEP);
            req_left <= ddr3_rd_burst_cnt;
        end else if (rd_grant) begin
            rd_addr  <= rd_addr + `DDR3_APP_ADDR_W'(`DDR3_ADDR_STEP);
            req_left <= req_left - `DDR3_BURST_CNT_W'(1);
        end
    end

    // ****************************************
    // return side
    // ****************************************

    // one-based index of the beat now arriving
    assign beat_next = beat_cnt + `DDR3_BURST_CNT_W'(1);
    assign last_hit  = app_rd_data_valid && (beat_next == burst_total);

    // beat counter, run length and done flag
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_total  <= '0;
            beat_cnt     <= '0;
            reading_done <= 1'b0;
        end else if (enable_reading) begin
            burst_total  <= ddr3_rd_burst_cnt;
            beat_cnt     <= '0;
            reading_done <= 1'b0;
        end else if (app_rd_data_valid) begin
            beat_cnt <= beat_next;
            // rises with the final FIFO write, sticks until next run
            if (last_hit) begin
                reading_done <= 1'b1;
            end
        end
    end

    // write strobe of the output stage
    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            ddr3_rd_fifo_wr_en <= 1'b0;
        end else begin
            ddr3_rd_fifo_wr_en <= app_rd_data_valid;
        end
    end

    // data and last marker, one cycle behind valid
    always_ff @(posedge ddr3_domain_clk) begin
        if (app_rd_data_valid) begin
            ddr3_rd_fifo_beat <= '{data: app_rd_data, last: last_hit};
        end
    end

    // memory returns no more beats than were requested
    a_no_extra_beat: assert property (
        @(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_rd_data_valid |-> (beat_cnt < burst_total)
    );

endmodule

`default_nettype wire

//--- ddr3_intf.sv
`default_nettype none

`include "ddr3_config.svh"

module ddr3_intf (
    input  wire logic                          ddr3_domain_clk,
    input  wire logic                          rst_n,
    // acquisition mode level
    input  wire logic                          acq_enabled,
    // sample FIFO, write path
    input  wire logic                          ddr3_wr_fifo_empty,
    input  wire logic [`DDR3_DATA_W-1:0]       ddr3_wr_fifo_dat,
    output logic                               ddr3_wr_fifo_rd_en,
    // readout control
    input  wire logic [`DDR3_BURST_ADDR_W-1:0] ddr3_rd_start_addr,
    input  wire logic [`DDR3_BURST_CNT_W-1:0]  ddr3_rd_burst_cnt,
    input  wire logic                          enable_reading,
    output logic                               reading_done,
    // read FIFO
    output logic                               ddr3_rd_fifo_wr_en,
    output ddr3_pkg::rd_beat_t                 ddr3_rd_fifo_beat,
    input  wire logic                          ddr3_rd_fifo_almost_full,
    // application port, command
    output ddr3_pkg::app_cmd_t                 app_cmd,
    output logic                               app_en,
    input  wire logic                          app_rdy,
    // application port, write data
    output logic [`DDR3_DATA_W-1:0]            app_wdf_data,
    output logic                               app_wdf_wren,
    output logic                               app_wdf_end,
    input  wire logic                          app_wdf_rdy,
    // application port, read data
    input  wire logic [`DDR3_DATA_W-1:0]       app_rd_data,
    input  wire logic                          app_rd_data_valid
);

    // requester to arbiter links
    logic               wr_req;
    ddr3_pkg::app_cmd_t wr_cmd;
    logic               wr_grant;
    logic               rd_req;
    ddr3_pkg::app_cmd_t rd_cmd;
    logic               rd_grant;

    // ****************************************
    // write path
    // ****************************************
    ddr3_wr_control u_wr_control (
        .ddr3_domain_clk    (ddr3_domain_clk),
        .rst_n              (rst_n),
        .ddr3_wr_fifo_empty (ddr3_wr_fifo_empty),
        .ddr3_wr_fifo_dat   (ddr3_wr_fifo_dat),
        .ddr3_wr_fifo_rd_en (ddr3_wr_fifo_rd_en),
        .wr_req             (wr_req),
        .wr_cmd             (wr_cmd),
        .wr_grant           (wr_grant),
        .app_wdf_data       (app_wdf_data),
        .app_wdf_wren       (app_wdf_wren),
        .app_wdf_end        (app_wdf_end),
        .app_wdf_rdy        (app_wdf_rdy)
    );

    // ****************************************
    // shared command slot
    // ****************************************
    ddr3_cmd_arbiter u_cmd_arbiter (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n),
        .acq_enabled     (acq_enabled),
        .wr_req          (wr_req),
        .wr_cmd          (wr_cmd),
        .wr_grant        (wr_grant),
        .rd_req          (rd_req),
        .rd_cmd          (rd_cmd),
        .rd_grant        (rd_grant),
        .app_cmd         (app_cmd),
        .app_en          (app_en),
        .app_rdy         (app_rdy)
    );

    // ****************************************
    // read path
    // ****************************************
    ddr3_rd_control u_rd_control (
        .ddr3_domain_clk          (ddr3_domain_clk),
        .rst_n                    (rst_n),
        .ddr3_rd_start_addr       (ddr3_rd_start_addr),
        .ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
        .enable_reading           (enable_reading),
        .reading_done             (reading_done),
        .rd_req                   (rd_req),
        .rd_cmd                   (rd_cmd),
        .rd_grant                 (rd_grant),
        .app_rd_data              (app_rd_data),
        .app_rd_data_valid        (app_rd_data_valid),
        .ddr3_rd_fifo_wr_en       (ddr3_rd_fifo_wr_en),
        .ddr3_rd_fifo_beat        (ddr3_rd_fifo_beat),
        .ddr3_rd_fifo_almost_full (ddr3_rd_fifo_almost_full)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 10
) (
    output logic ddr3_domain_clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // free-running clock, low at time zero
    initial begin
        ddr3_domain_clk = 1'b0;
        forever #(PERIOD_NS / 2) ddr3_domain_clk = ~ddr3_domain_clk;
    end

    // reset held for a fixed number of edges, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge ddr3_domain_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_ddr3_intf.sv
`default_nettype none

`include "ddr3_config.svh"

module tb_ddr3_intf;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD_NS = 20;
    localparam int          RST_CYCLES    = 10;
    localparam logic [31:0] SEED          = 32'hd6978ed7;
    // run lengths in words or bursts
    localparam int N_WR_WORDS  = 16;
    localparam int N_RD_BURSTS = 10;
    localparam int N_BP_BURSTS = 12;
    localparam int N_ARB_WORDS = 6;
    // 200 cycles per word or burst
    localparam int WATCHDOG_NS =
        (N_WR_WORDS + N_RD_BURSTS + N_BP_BURSTS + N_ARB_WORDS) * 200 * CLK_PERIOD_NS;

    logic                          ddr3_domain_clk;
    logic                          rst_n;
    logic                          acq_enabled;
    logic                          ddr3_wr_fifo_empty = 1'b1;
    logic [`DDR3_DATA_W-1:0]       ddr3_wr_fifo_dat   = '0;
    logic                          ddr3_wr_fifo_rd_en;
    logic [`DDR3_BURST_ADDR_W-1:0] ddr3_rd_start_addr;
    logic [`DDR3_BURST_CNT_W-1:0]  ddr3_rd_burst_cnt;
    logic                          enable_reading;
    logic                          reading_done;
    logic                          ddr3_rd_fifo_wr_en;
    ddr3_pkg::rd_beat_t            ddr3_rd_fifo_beat;
    logic                          ddr3_rd_fifo_almost_full;
    ddr3_pkg::app_cmd_t            app_cmd;
    logic                          app_en;
    logic                          app_rdy = 1'b0;
    logic [`DDR3_DATA_W-1:0]       app_wdf_data;
    logic                          app_wdf_wren;
    logic                          app_wdf_end;
    logic                          app_wdf_rdy = 1'b0;
    logic [`DDR3_DATA_W-1:0]       app_rd_data = '0;
    logic                          app_rd_data_valid = 1'b0;

    // ****************************************
    // scoreboard state
    // ****************************************
    logic [`DDR3_DATA_W-1:0]     wr_fifo_q[$];
    logic [`DDR3_DATA_W-1:0]     popped_q[$];
    logic [`DDR3_DATA_W-1:0]     wdata_q[$];
    ddr3_pkg::app_cmd_t          cmd_q[$];
    logic [`DDR3_APP_ADDR_W-1:0] rd_pend_addr[$];
    int                          rd_pend_due[$];
    int                          cyc        = 0;
    int                          last_due   = 0;
    int                          wr_acc_cnt = 0;
    int                          rd_acc_cnt = 0;
    int                          wdata_cnt  = 0;
    int                          words_sent = 0;
    // next write index times eight gives its address
    int                          wr_idx     = 0;
    // current read run as loaded by enable_reading
    int                          run_start  = 0;
    int                          run_cnt    = 0;
    int                          beat_idx   = 0;
    logic                        done_exp   = 1'b0;
    logic                        prev_valid = 1'b0;

    tb_clk_gen #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) clk_gen0 (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n)
    );

    ddr3_intf dut0 (
        .ddr3_domain_clk          (ddr3_domain_clk),
        .rst_n                    (rst_n),
        .acq_enabled              (acq_enabled),
        .ddr3_wr_fifo_empty       (ddr3_wr_fifo_empty),
        .ddr3_wr_fifo_dat         (ddr3_wr_fifo_dat),
        .ddr3_wr_fifo_rd_en       (ddr3_wr_fifo_rd_en),
        .ddr3_rd_start_addr       (ddr3_rd_start_addr),
        .ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
        .enable_reading           (enable_reading),
        .reading_done             (reading_done),
        .ddr3_rd_fifo_wr_en       (ddr3_rd_fifo_wr_en),
        .ddr3_rd_fifo_beat        (ddr3_rd_fifo_beat),
        .ddr3_rd_fifo_almost_full (ddr3_rd_fifo_almost_full),
        .app_cmd                  (app_cmd),
        .app_en                   (app_en),
        .app_rdy                  (app_rdy),
        .app_wdf_data             (app_wdf_data),
        .app_wdf_wren             (app_wdf_wren),
        .app_wdf_end              (app_wdf_end),
        .app_wdf_rdy              (app_wdf_rdy),
        .app_rd_data              (app_rd_data),
        .app_rd_data_valid        (app_rd_data_valid)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_cmd(input ddr3_pkg::app_cmd_t got, input ddr3_pkg::app_cmd_t exp,
                             input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0d ns: %s command %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_beat(input ddr3_pkg::rd_beat_t got, input ddr3_pkg::rd_beat_t exp,
                              input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0d ns: %s %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_data(input logic [`DDR3_DATA_W-1:0] got,
                              input logic [`DDR3_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0d ns: %s %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // memory contents as a fixed function of the address
    function automatic logic [`DDR3_DATA_W-1:0] model_data(
        input logic [`DDR3_APP_ADDR_W-1:0] a
    );
        logic [31:0] w;
        w = 32'(a);
        return {w ^ 32'hdead_beef, ~w, w * 32'h9e37_79b1, w + 32'h0135_7000};
    endfunction

    // ****************************************
    // memory model behind the app port
    // ****************************************
    always @(posedge ddr3_domain_clk) begin : port_model
        int due;
        cyc = cyc + 1;
        // stall about one cycle in four
        app_rdy     <= ($urandom % 4) != 0;
        app_wdf_rdy <= ($urandom % 4) != 0;
        if (app_en && app_rdy) begin
            cmd_q.push_back(app_cmd);
            if (app_cmd.cmd == ddr3_pkg::APP_CMD_WRITE) begin
                wr_acc_cnt++;
            end else begin
                rd_acc_cnt++;
                // random latency with data still in issue order
                due = cyc + 2 + int'($urandom % 5);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rd_pend_addr.push_back(app_cmd.addr);
                rd_pend_due.push_back(due);
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            wdata_q.push_back(app_wdf_data);
            wdata_cnt++;
            // every write is one beat that closes its burst
            check_flag(app_wdf_end, 1'b1, "app_wdf_end on a write beat");
        end else if (!app_wdf_wren) begin
            // no burst end outside a write strobe
            check_flag(app_wdf_end, 1'b0, "app_wdf_end without app_wdf_wren");
        end
        if (rd_pend_addr.size() > 0 && rd_pend_due[0] <= cyc) begin
            app_rd_data_valid <= 1'b1;
            app_rd_data       <= model_data(rd_pend_addr.pop_front());
            void'(rd_pend_due.pop_front());
        end else begin
            app_rd_data_valid <= 1'b0;
        end
    end

    // sample FIFO with data showing up the cycle after rd_en
    always @(posedge ddr3_domain_clk) begin : wr_fifo_model
        logic [`DDR3_DATA_W-1:0] word;
        if (ddr3_wr_fifo_rd_en) begin
            if (wr_fifo_q.size() == 0) begin
                fail_run("write FIFO was popped while empty");
            end else begin
                word = wr_fifo_q.pop_front();
                ddr3_wr_fifo_dat <= word;
                popped_q.push_back(word);
            end
        end
        ddr3_wr_fifo_empty <= (wr_fifo_q.size() == 0);
    end

    // read FIFO side sees each valid beat one cycle later
    always @(posedge ddr3_domain_clk) begin : beat_monitor
        ddr3_pkg::rd_beat_t          exp_beat;
        logic [`DDR3_APP_ADDR_W-1:0] exp_addr;
        if (rst_n) begin
            check_flag(ddr3_rd_fifo_wr_en, prev_valid, "read FIFO write enable");
            if (prev_valid) begin
                beat_idx++;
                exp_addr = `DDR3_APP_ADDR_W'((run_start + beat_idx - 1) * `DDR3_ADDR_STEP);
                exp_beat = '{data: model_data(exp_addr), last: (beat_idx == run_cnt)};
                check_beat(ddr3_rd_fifo_beat, exp_beat, "read FIFO beat");
                // done rises together with the last beat
                if (exp_beat.last) begin
                    done_exp = 1'b1;
                end
            end
            check_flag(reading_done, done_exp, "reading_done");
            if (enable_reading) begin
                done_exp = 1'b0;
                beat_idx = 0;
            end
            prev_valid = app_rd_data_valid;
        end
    end

    // ****************************************
    // stimulus helpers
    // ****************************************
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ddr3_domain_clk);
    endtask

    task automatic push_words(input int n);
        @(negedge ddr3_domain_clk);
        repeat (n) begin
            wr_fifo_q.push_back({$urandom, $urandom, $urandom, $urandom});
        end
        words_sent += n;
    endtask

    task automatic wait_writes();
        while (wr_acc_cnt < words_sent || wdata_cnt < words_sent) begin
            @(negedge ddr3_domain_clk);
        end
    endtask

    // n-th popped word at address n times eight
    task automatic check_writes(input int n);
        ddr3_pkg::app_cmd_t exp_cmd;
        for (int i = 0; i < n; i++) begin
            if (cmd_q.size() == 0 || wdata_q.size() == 0 || popped_q.size() == 0) begin
                fail_run("fewer writes completed than words popped");
            end
            exp_cmd = '{cmd: ddr3_pkg::APP_CMD_WRITE,
                        addr: `DDR3_APP_ADDR_W'(wr_idx * `DDR3_ADDR_STEP)};
            check_cmd(cmd_q.pop_front(), exp_cmd, "write");
            check_data(wdata_q.pop_front(), popped_q.pop_front(), "write data");
            wr_idx++;
        end
    endtask

    task automatic start_read_run(input int start, input int cnt);
        @(negedge ddr3_domain_clk);
        run_start = start;
        run_cnt   = cnt;
        @(posedge ddr3_domain_clk);
        ddr3_rd_start_addr <= `DDR3_BURST_ADDR_W'(start);
        ddr3_rd_burst_cnt  <= `DDR3_BURST_CNT_W'(cnt);
        enable_reading     <= 1'b1;
        @(posedge ddr3_domain_clk);
        enable_reading     <= 1'b0;
    endtask

    task automatic wait_read_done();
        do begin
            @(negedge ddr3_domain_clk);
        end while (!reading_done);
        // monitor still has the final beat to check
        wait_cycles(2);
        @(negedge ddr3_domain_clk);
    endtask

    task automatic check_reads(input int start, input int cnt);
        ddr3_pkg::app_cmd_t exp_cmd;
        if (beat_idx != cnt) begin
            fail_run($sformatf("FAIL %0d ns: %0d beats returned, expected %0d",
                               $time, beat_idx, cnt));
        end
        for (int i = 0; i < cnt; i++) begin
            if (cmd_q.size() == 0) begin
                fail_run("fewer read commands accepted than the burst count");
            end
            exp_cmd = '{cmd: ddr3_pkg::APP_CMD_READ,
                        addr: `DDR3_APP_ADDR_W'((start + i) * `DDR3_ADDR_STEP)};
            check_cmd(cmd_q.pop_front(), exp_cmd, "read");
        end
        if (cmd_q.size() != 0) begin
            fail_run("more read commands accepted than the burst count");
        end
    endtask

    // ****************************************
    // directed tests
    // ****************************************
    task automatic test_write_path();
        @(posedge ddr3_domain_clk);
        acq_enabled <= 1'b1;
        wait_cycles(4);
        push_words(N_WR_WORDS);
        wait_writes();
        check_writes(N_WR_WORDS);
    endtask

    task automatic test_read_path();
        @(posedge ddr3_domain_clk);
        acq_enabled <= 1'b0;
        wait_cycles(4);
        start_read_run(40, N_RD_BURSTS);
        wait_read_done();
        check_reads(40, N_RD_BURSTS);
    endtask

    task automatic test_rd_backpressure();
        int base;
        int held;
        @(negedge ddr3_domain_clk);
        base = rd_acc_cnt;
        start_read_run(200, N_BP_BURSTS);
        while (rd_acc_cnt < base + 2) begin
            @(negedge ddr3_domain_clk);
        end
        @(posedge ddr3_domain_clk);
        ddr3_rd_fifo_almost_full <= 1'b1;
        // only a command already in the slot may still go out
        wait_cycles(2);
        @(negedge ddr3_domain_clk);
        held = rd_acc_cnt;
        wait_cycles(20);
        @(negedge ddr3_domain_clk);
        if (rd_acc_cnt > held + 1) begin
            fail_run($sformatf("FAIL %0d ns: %0d reads accepted under almost_full",
                               $time, rd_acc_cnt - held));
        end
        @(posedge ddr3_domain_clk);
        ddr3_rd_fifo_almost_full <= 1'b0;
        wait_read_done();
        check_reads(200, N_BP_BURSTS);
    endtask

    task automatic test_arbitration();
        int held;
        @(posedge ddr3_domain_clk);
        acq_enabled <= 1'b1;
        wait_cycles(4);
        // words arrive just as acquisition stops
        push_words(N_ARB_WORDS);
        held = wr_acc_cnt;
        @(posedge ddr3_domain_clk);
        acq_enabled <= 1'b0;
        wait_cycles(40);
        @(negedge ddr3_domain_clk);
        if (wr_acc_cnt > held + 1) begin
            fail_run($sformatf("FAIL %0d ns: %0d writes issued with acq_enabled low",
                               $time, wr_acc_cnt - held));
        end
        @(posedge ddr3_domain_clk);
        acq_enabled <= 1'b1;
        wait_writes();
        check_writes(N_ARB_WORDS);
    endtask

    initial begin
        void'($urandom(SEED));
        acq_enabled              <= 1'b0;
        ddr3_rd_start_addr       <= '0;
        ddr3_rd_burst_cnt        <= '0;
        enable_reading           <= 1'b0;
        ddr3_rd_fifo_almost_full <= 1'b0;
        wait (rst_n === 1'b1);
        wait_cycles(2);
        test_write_path();
        test_read_path();
        test_rd_backpressure();
        test_arbitration();
        wait_cycles(10);
        @(negedge ddr3_domain_clk);
        // every command and data word must be matched by now
        if (cmd_q.size() != 0 || wdata_q.size() != 0 || wr_fifo_q.size() != 0) begin
            fail_run("commands or write data left over after the last test");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the directed tests finished");
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
ddr3_pkg.sv
ddr3_wr_control.sv
ddr3_cmd_arbiter.sv
ddr3_rd_control.sv
ddr3_intf.sv
tb_clk_gen.sv
tb_ddr3_intf.sv

//--- Bender.yml
package:
  name: ddr3_intf

sources:
  - include_dirs:
      - .
    files:
      - ddr3_pkg.sv
      - ddr3_wr_control.sv
      - ddr3_cmd_arbiter.sv
      - ddr3_rd_control.sv
      - ddr3_intf.sv
      - target: test
        include_dirs:
          - .
        files:
          - tb_clk_gen.sv
          - tb_ddr3_intf.sv
